// File: fx3_bridge.f
src/fx3_pkg.sv
src/fx3_apb_decode.sv
src/fx3_gpif_engine.sv
src/fx3_apb_result.sv
src/fx3_bridge_top.sv
test/fx3_device_model.sv
test/fx3_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator and runs it.
# The exit status is zero only when the run reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
  --top-module fx3_bridge_tb \
  -f fx3_bridge.f \
  -o fx3_bridge_sim

output=$(./obj_dir/fx3_bridge_sim)
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: src/fx3_apb_decode.sv
// ********************************************************
// APB register decoder of the slave FIFO bridge
// Classifies each access in the setup phase, keeps the
// socket number and hands bridge accesses to the engine
// PREADY is stretched until the engine reports done
// ********************************************************

module fx3_apb_decode (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [fx3_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [fx3_pkg::DATA_WIDTH-1:0]     pwdata_i,
  input  logic                               cmd_done_i,
  input  logic                               cmd_error_i,
  output logic                               pready_o,
  output logic                               pslverr_o,
  output logic                               cmd_valid_o,
  output fx3_pkg::cmd_e                      cmd_kind_o,
  output logic [fx3_pkg::DATA_WIDTH-1:0]     cmd_data_o,
  output logic [fx3_pkg::SOCKET_WIDTH-1:0]   socket_o,
  output logic [fx3_pkg::APB_ADDR_WIDTH-1:0] reg_sel_o,
  output logic                               rd_strobe_o,
  output logic                               txcount_clr_o,
  output logic                               rxcount_clr_o
);

  import fx3_pkg::*;

  logic setup_phase;
  logic access_phase;
  logic access_done;
  logic acc_legal;
  logic acc_bridge;
  cmd_e acc_kind;
  logic err_q;
  logic bridge_q;

  assign setup_phase  = psel_i & ~penable_i;
  assign access_phase = psel_i & penable_i;

  // Offset and direction decide whether the access is legal
  // and whether it needs a bus cycle on the bridge side
  always_comb begin
    acc_legal  = 1'b1;
    acc_bridge = 1'b0;
    acc_kind   = CMD_WRITE;
    case (paddr_i)
      REG_CONFIG, REG_TXCOUNT, REG_RXCOUNT: begin
        acc_legal = 1'b1;
      end
      REG_TXDATA: begin
        acc_legal  = pwrite_i;
        acc_bridge = pwrite_i;
        acc_kind   = CMD_WRITE;
      end
      REG_RXDATA: begin
        acc_legal  = ~pwrite_i;
        acc_bridge = ~pwrite_i;
        acc_kind   = CMD_READ;
      end
      REG_STATUS: begin
        acc_legal = ~pwrite_i;
      end
      REG_PKTEND: begin
        acc_legal  = pwrite_i;
        acc_bridge = pwrite_i;
        acc_kind   = CMD_PKTEND;
      end
      default: begin
        acc_legal = 1'b0;
      end
    endcase
  end

  // ********************************************************
  // Setup phase capture and command handshake
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_sel_o   <= '0;
      err_q       <= 1'b0;
      bridge_q    <= 1'b0;
      cmd_valid_o <= 1'b0;
      cmd_kind_o  <= CMD_WRITE;
    end else begin
      if (setup_phase) begin
        reg_sel_o <= paddr_i;
        err_q     <= ~acc_legal;
        bridge_q  <= acc_bridge;
      end
      // The request is held until the engine answers with done
      if (setup_phase && acc_bridge) begin
        cmd_valid_o <= 1'b1;
        cmd_kind_o  <= acc_kind;
      end else if (cmd_done_i) begin
        cmd_valid_o <= 1'b0;
      end
    end
  end

  // Write data goes straight to the engine with the command
  always_ff @(posedge clk) begin
    if (setup_phase && pwrite_i) begin
      cmd_data_o <= pwdata_i;
    end
  end

  // Register accesses finish in the first access cycle
  assign access_done = access_phase & (bridge_q ? cmd_done_i : 1'b1);
  assign pready_o    = access_done;
  assign pslverr_o   = access_done & (err_q | (bridge_q & cmd_error_i));
  assign rd_strobe_o = access_done & ~pwrite_i & ~pslverr_o;

  assign txcount_clr_o = access_done & pwrite_i & (reg_sel_o == REG_TXCOUNT);
  assign rxcount_clr_o = access_done & pwrite_i & (reg_sel_o == REG_RXCOUNT);

  // Socket selection for addr and the fifo_rdy check
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      socket_o <= '0;
    end else if (access_done && pwrite_i && reg_sel_o == REG_CONFIG) begin
      socket_o <= pwdata_i[SOCKET_WIDTH-1:0];
    end
  end

endmodule

// File: src/fx3_apb_result.sv
// ********************************************************
// Readback and counter block of the slave FIFO bridge
// Counts good writes and reads and builds PRDATA for
// every readable register
// PRDATA is zero outside a completing read
// ********************************************************

module fx3_apb_result (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic [fx3_pkg::APB_ADDR_WIDTH-1:0] reg_sel_i,
  input  logic                               rd_strobe_i,
  input  logic                               cmd_done_i,
  input  logic                               cmd_error_i,
  input  fx3_pkg::cmd_e                      cmd_kind_i,
  input  logic [fx3_pkg::DATA_WIDTH-1:0]     rd_data_i,
  input  logic [fx3_pkg::SOCKET_WIDTH-1:0]   socket_i,
  input  logic [fx3_pkg::NUM_SOCKETS-1:0]    fifo_rdy_i,
  input  logic                               busy_i,
  input  logic                               txcount_clr_i,
  input  logic                               rxcount_clr_i,
  output logic [fx3_pkg::DATA_WIDTH-1:0]     prdata_o
);

  import fx3_pkg::*;

  logic [COUNT_WIDTH-1:0] tx_count_q;
  logic [COUNT_WIDTH-1:0] rx_count_q;
  logic [DATA_WIDTH-1:0]  rd_mux;
  logic                   cmd_ok;

  // Only commands that ended without a timeout count
  assign cmd_ok = cmd_done_i & ~cmd_error_i;

  // ********************************************************
  // Transfer counters
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_count_q <= '0;
      rx_count_q <= '0;
    end else begin
      if (txcount_clr_i) begin
        tx_count_q <= '0;
      end else if (cmd_ok && cmd_kind_i == CMD_WRITE) begin
        tx_count_q <= tx_count_q + 1'b1;
      end
      if (rxcount_clr_i) begin
        rx_count_q <= '0;
      end else if (cmd_ok && cmd_kind_i == CMD_READ) begin
        rx_count_q <= rx_count_q + 1'b1;
      end
    end
  end

  // Read multiplexer, unused bits read as zero
  always_comb begin
    rd_mux = '0;
    case (reg_sel_i)
      REG_CONFIG: begin
        rd_mux[SOCKET_WIDTH-1:0] = socket_i;
      end
      REG_RXDATA: begin
        rd_mux = rd_data_i;
      end
      REG_STATUS: begin
        rd_mux[NUM_SOCKETS-1:0]  = fifo_rdy_i;
        rd_mux[STATUS_BUSY_BIT]  = busy_i;
      end
      REG_TXCOUNT: begin
        rd_mux[COUNT_WIDTH-1:0] = tx_count_q;
      end
      REG_RXCOUNT: begin
        rd_mux[COUNT_WIDTH-1:0] = rx_count_q;
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  assign prdata_o = rd_strobe_i ? rd_mux : '0;

endmodule

// File: src/fx3_bridge_top.sv
// ********************************************************
// APB to USB 3.0 slave FIFO bridge, top level
// Wires the decoder, the bus-cycle engine and the readback
// block together; the board top adds the data tristate
// buffer from data_i, data_o and data_t_o
// ********************************************************

module fx3_bridge_top #(
  parameter int READ_LATENCY   = 2,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  logic                               clk,
  input  logic                               rst_n_i,

  // APB slave
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [fx3_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [fx3_pkg::DATA_WIDTH-1:0]     pwdata_i,
  output logic [fx3_pkg::DATA_WIDTH-1:0]     prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,

  // Slave FIFO pins
  input  logic [fx3_pkg::NUM_SOCKETS-1:0]    fifo_rdy_i,
  input  logic [fx3_pkg::DATA_WIDTH-1:0]     data_i,
  output logic [fx3_pkg::DATA_WIDTH-1:0]     data_o,
  output logic                               data_t_o,
  output logic [fx3_pkg::SOCKET_WIDTH-1:0]   addr_o,
  output logic                               pclk_o,
  output logic                               slcs_n_o,
  output logic                               slrd_n_o,
  output logic                               sloe_n_o,
  output logic                               slwr_n_o,
  output logic                               pktend_n_o
);

  import fx3_pkg::*;

  // ********************************************************
  // Internal signals
  // ********************************************************

  logic                      cmd_valid;
  cmd_e                      cmd_kind;
  logic [DATA_WIDTH-1:0]     cmd_data;
  logic [SOCKET_WIDTH-1:0]   socket;
  logic                      cmd_done;
  logic                      cmd_error;
  logic [DATA_WIDTH-1:0]     rd_data;
  logic                      busy;
  logic [APB_ADDR_WIDTH-1:0] reg_sel;
  logic                      rd_strobe;
  logic                      txcount_clr;
  logic                      rxcount_clr;

  // The device runs from the same clock as the bridge logic
  assign pclk_o = clk;

  fx3_apb_decode i_decode (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .cmd_done_i    (cmd_done),
    .cmd_error_i   (cmd_error),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .cmd_valid_o   (cmd_valid),
    .cmd_kind_o    (cmd_kind),
    .cmd_data_o    (cmd_data),
    .socket_o      (socket),
    .reg_sel_o     (reg_sel),
    .rd_strobe_o   (rd_strobe),
    .txcount_clr_o (txcount_clr),
    .rxcount_clr_o (rxcount_clr));

  fx3_gpif_engine #(
    .READ_LATENCY   (READ_LATENCY),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_engine (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_kind_i  (cmd_kind),
    .cmd_data_i  (cmd_data),
    .socket_i    (socket),
    .fifo_rdy_i  (fifo_rdy_i),
    .data_i      (data_i),
    .cmd_done_o  (cmd_done),
    .cmd_error_o (cmd_error),
    .rd_data_o   (rd_data),
    .busy_o      (busy),
    .data_o      (data_o),
    .data_t_o    (data_t_o),
    .addr_o      (addr_o),
    .slcs_n_o    (slcs_n_o),
    .slrd_n_o    (slrd_n_o),
    .sloe_n_o    (sloe_n_o),
    .slwr_n_o    (slwr_n_o),
    .pktend_n_o  (pktend_n_o));

  fx3_apb_result i_result (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .reg_sel_i     (reg_sel),
    .rd_strobe_i   (rd_strobe),
    .cmd_done_i    (cmd_done),
    .cmd_error_i   (cmd_error),
    .cmd_kind_i    (cmd_kind),
    .rd_data_i     (rd_data),
    .socket_i      (socket),
    .fifo_rdy_i    (fifo_rdy_i),
    .busy_i        (busy),
    .txcount_clr_i (txcount_clr),
    .rxcount_clr_i (rxcount_clr),
    .prdata_o      (prdata_o));

endmodule

// File: src/fx3_gpif_engine.sv
// ********************************************************
// Slave FIFO bus-cycle engine
// Runs one single-word write, read or packet end per
// command, waiting on fifo_rdy of the selected socket
// All bridge pins come straight from flops
// ********************************************************

module fx3_gpif_engine #(
  parameter int READ_LATENCY   = 2,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             cmd_valid_i,
  input  fx3_pkg::cmd_e                    cmd_kind_i,
  input  logic [fx3_pkg::DATA_WIDTH-1:0]   cmd_data_i,
  input  logic [fx3_pkg::SOCKET_WIDTH-1:0] socket_i,
  input  logic [fx3_pkg::NUM_SOCKETS-1:0]  fifo_rdy_i,
  input  logic [fx3_pkg::DATA_WIDTH-1:0]   data_i,
  output logic                             cmd_done_o,
  output logic                             cmd_error_o,
  output logic [fx3_pkg::DATA_WIDTH-1:0]   rd_data_o,
  output logic                             busy_o,
  output logic [fx3_pkg::DATA_WIDTH-1:0]   data_o,
  output logic                             data_t_o,
  output logic [fx3_pkg::SOCKET_WIDTH-1:0] addr_o,
  output logic                             slcs_n_o,
  output logic                             slrd_n_o,
  output logic                             sloe_n_o,
  output logic                             slwr_n_o,
  output logic                             pktend_n_o
);

  import fx3_pkg::*;

  localparam int LAT_W = $clog2(READ_LATENCY + 1);
  localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(READ_LATENCY);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(TIMEOUT_CYCLES - 1);

  // FSM states
  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_WAIT    = 3'd1;
  localparam logic [2:0] ST_STROBE  = 3'd2;
  localparam logic [2:0] ST_LATENCY = 3'd3;
  localparam logic [2:0] ST_DONE    = 3'd4;

  logic [2:0]       state_q;
  logic [TMO_W-1:0] tmo_cnt_q;
  logic [LAT_W-1:0] lat_cnt_q;
  logic             sample;

  // Read data is taken in the last latency cycle
  assign sample = (state_q == ST_LATENCY) && (lat_cnt_q == LAT_LAST);

  // ********************************************************
  // Bus-cycle FSM
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      tmo_cnt_q   <= '0;
      lat_cnt_q   <= '0;
      cmd_done_o  <= 1'b0;
      cmd_error_o <= 1'b0;
      busy_o      <= 1'b0;
      addr_o      <= '0;
      data_t_o    <= 1'b1;
      slcs_n_o    <= 1'b1;
      slrd_n_o    <= 1'b1;
      sloe_n_o    <= 1'b1;
      slwr_n_o    <= 1'b1;
      pktend_n_o  <= 1'b1;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_valid_i) begin
            // Socket is latched so addr stays put for the whole cycle
            addr_o    <= socket_i;
            busy_o    <= 1'b1;
            tmo_cnt_q <= '0;
            state_q   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (fifo_rdy_i[addr_o]) begin
            slcs_n_o <= 1'b0;
            case (cmd_kind_i)
              CMD_WRITE: begin
                slwr_n_o <= 1'b0;
                data_t_o <= 1'b0;
              end
              CMD_READ: begin
                slrd_n_o <= 1'b0;
                sloe_n_o <= 1'b0;
              end
              default: begin
                pktend_n_o <= 1'b0;
              end
            endcase
            state_q <= ST_STROBE;
          end else if (tmo_cnt_q == TMO_LAST) begin
            // Socket never became ready, give up without a strobe
            cmd_done_o  <= 1'b1;
            cmd_error_o <= 1'b1;
            state_q     <= ST_DONE;
          end else begin
            tmo_cnt_q <= tmo_cnt_q + 1'b1;
          end
        end
        ST_STROBE: begin
          slcs_n_o   <= 1'b1;
          slrd_n_o   <= 1'b1;
          slwr_n_o   <= 1'b1;
          pktend_n_o <= 1'b1;
          data_t_o   <= 1'b1;
          if (cmd_kind_i == CMD_READ) begin
            // sloe_n stays low while the device pipeline fills
            lat_cnt_q <= LAT_W'(1);
            state_q   <= ST_LATENCY;
          end else begin
            cmd_done_o <= 1'b1;
            state_q    <= ST_DONE;
          end
        end
        ST_LATENCY: begin
          if (sample) begin
            sloe_n_o   <= 1'b1;
            cmd_done_o <= 1'b1;
            state_q    <= ST_DONE;
          end else begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
          end
        end
        default: begin
          cmd_done_o  <= 1'b0;
          cmd_error_o <= 1'b0;
          busy_o      <= 1'b0;
          state_q     <= ST_IDLE;
        end
      endcase
    end
  end

  // Payload registers for the data bus
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && cmd_valid_i) begin
      data_o <= cmd_data_i;
    end
    if (sample) begin
      rd_data_o <= data_i;
    end
  end

endmodule

// File: src/fx3_pkg.sv
// ********************************************************
// Shared constants for the USB 3.0 slave FIFO bridge
// APB register map, bus widths and the engine command code
// Every bridge module imports what it needs from here
// ********************************************************

package fx3_pkg;

  // Bus widths
  localparam int APB_ADDR_WIDTH = 8;
  localparam int DATA_WIDTH     = 32;
  localparam int SOCKET_WIDTH   = 2;
  localparam int COUNT_WIDTH    = 16;

  // One fifo_rdy bit per socket
  localparam int NUM_SOCKETS    = 1 << SOCKET_WIDTH;

  // ********************************************************
  // APB register offsets
  // ********************************************************

  // Socket number lives in bits 1:0
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CONFIG  = 8'h00;
  // Write only, one word to the selected socket
  localparam logic [APB_ADDR_WIDTH-1:0] REG_TXDATA  = 8'h04;
  // Read only, one word from the selected socket
  localparam logic [APB_ADDR_WIDTH-1:0] REG_RXDATA  = 8'h08;
  // Read only, fifo_rdy in bits 3:0 and engine busy in bit 4
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS  = 8'h0C;
  // Write only, any value closes the current packet
  localparam logic [APB_ADDR_WIDTH-1:0] REG_PKTEND  = 8'h10;
  // Transfer counters, a write of any value clears them
  localparam logic [APB_ADDR_WIDTH-1:0] REG_TXCOUNT = 8'h14;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_RXCOUNT = 8'h18;

  // Position of the busy flag in STATUS
  localparam int STATUS_BUSY_BIT = 4;

  // Commands from the APB decoder to the bus-cycle engine
  typedef enum logic [1:0] {
    CMD_WRITE  = 2'd0,
    CMD_READ   = 2'd1,
    CMD_PKTEND = 2'd2
  } cmd_e;

endpackage

// File: test/fx3_bridge_tb.sv
// ********************************************************
// Testbench for the APB to slave FIFO bridge
// Drives APB accesses on the falling clock edge against a
// behavioral bridge chip model and runs directed tests
// for registers, writes, reads, stalls, errors and pktend
// ********************************************************

module fx3_bridge_tb;

  import fx3_pkg::*;

  // A non-default latency exercises the engine counter
  localparam int READ_LATENCY    = 3;
  localparam int TIMEOUT_CYCLES  = 32;
  // Upper bound on APB accesses over all tests
  localparam int NUM_ACCESSES    = 64;
  localparam int WATCHDOG_CYCLES = 16 + NUM_ACCESSES * (TIMEOUT_CYCLES + READ_LATENCY + 8);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [3:0]  rdy_ctrl;
  logic [3:0]  fifo_rdy;
  logic [31:0] dev_data;
  logic [31:0] bridge_data;
  logic        data_t;
  logic [1:0]  addr;
  logic        pclk;
  logic        slcs_n;
  logic        slrd_n;
  logic        sloe_n;
  logic        slwr_n;
  logic        pktend_n;
  logic        load;
  logic [1:0]  load_socket;
  logic [31:0] load_data;

  int seed;
  int err_count;
  int check_count;
  int last_waits;
  int tx_expected;
  int rx_expected;

  always #5 clk = ~clk;

  fx3_bridge_top #(
    .READ_LATENCY   (READ_LATENCY),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) uut (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr),
    .fifo_rdy_i (fifo_rdy),
    .data_i     (dev_data),
    .data_o     (bridge_data),
    .data_t_o   (data_t),
    .addr_o     (addr),
    .pclk_o     (pclk),
    .slcs_n_o   (slcs_n),
    .slrd_n_o   (slrd_n),
    .sloe_n_o   (sloe_n),
    .slwr_n_o   (slwr_n),
    .pktend_n_o (pktend_n));

  fx3_device_model #(
    .READ_LATENCY (READ_LATENCY)
  ) model (
    .pclk_i        (pclk),
    .rst_n_i       (rst_n),
    .ready_i       (rdy_ctrl),
    .load_i        (load),
    .load_socket_i (load_socket),
    .load_data_i   (load_data),
    .addr_i        (addr),
    .data_i        (bridge_data),
    .data_t_i      (data_t),
    .slcs_n_i      (slcs_n),
    .slrd_n_i      (slrd_n),
    .sloe_n_i      (sloe_n),
    .slwr_n_i      (slwr_n),
    .pktend_n_i    (pktend_n),
    .fifo_rdy_o    (fifo_rdy),
    .data_o        (dev_data));

  // ********************************************************
  // Helpers
  // ********************************************************

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, err_count - errs_before);
  endtask

  // One APB transfer, PREADY is sampled at the rising edge
  task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = wdata;
    @(negedge clk);
    penable    = 1'b1;
    last_waits = 0;
    @(posedge clk);
    while (!pready) begin
      last_waits++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] a, input logic [31:0] wdata, output logic err);
    logic [31:0] unused_rd;
    apb_access(1'b1, a, wdata, unused_rd, err);
  endtask

  task automatic apb_read(input logic [7:0] a, output logic [31:0] rdata, output logic err);
    apb_access(1'b0, a, 32'h0, rdata, err);
  endtask

  task automatic set_ready(input logic [3:0] mask);
    @(negedge clk);
    rdy_ctrl = mask;
  endtask

  // Puts one word into the read FIFO of a model socket
  task automatic load_word(input logic [1:0] s, input logic [31:0] w);
    @(negedge clk);
    load        = 1'b1;
    load_socket = s;
    load_data   = w;
    @(negedge clk);
    load = 1'b0;
  endtask

  // ********************************************************
  // Directed tests
  // ********************************************************

  task automatic reset_and_registers();
    int          errs;
    logic [31:0] rd;
    logic        err;
    errs = err_count;
    compare_value("pready after reset", 32'(pready), 32'd0);
    compare_value("pins after reset", 32'({slcs_n, slrd_n, sloe_n, slwr_n, pktend_n, data_t}),
                  32'h3F);
    apb_read(REG_STATUS, rd, err);
    // Busy is clear and the ready bits mirror the model
    compare_value("status after reset", rd, {27'd0, 1'b0, rdy_ctrl});
    compare_value("status error flag", 32'(err), 32'd0);
    apb_read(REG_TXCOUNT, rd, err);
    compare_value("txcount after reset", rd, 32'd0);
    apb_read(REG_RXCOUNT, rd, err);
    compare_value("rxcount after reset", rd, 32'd0);
    for (int s = 0; s < 4; s++) begin
      apb_write(REG_CONFIG, 32'(s), err);
      compare_value("config write error flag", 32'(err), 32'd0);
      apb_read(REG_CONFIG, rd, err);
      compare_value("config readback", rd, 32'(s));
    end
    report_test("reset_and_registers", errs);
  endtask

  task automatic word_writes();
    int          errs;
    logic [31:0] word;
    logic [31:0] rd;
    logic [5:0]  base;
    logic        err;
    errs = err_count;
    set_ready(4'hF);
    for (int s = 0; s < 4; s++) begin
      apb_write(REG_CONFIG, 32'(s), err);
      base = model.tx_ptr[2'(s)];
      for (int i = 0; i < 3; i++) begin
        word = $random(seed);
        apb_write(REG_TXDATA, word, err);
        tx_expected++;
        compare_value("write error flag", 32'(err), 32'd0);
        // Each word lands right behind the one before it
        compare_value("word in socket store", model.tx_mem[2'(s)][base + 6'(i)], word);
      end
      compare_value("words per socket", 32'(model.tx_ptr[2'(s)] - base), 32'd3);
    end
    apb_read(REG_TXCOUNT, rd, err);
    compare_value("txcount after writes", rd, 32'(tx_expected));
    report_test("word_writes", errs);
  endtask

  task automatic word_reads();
    int          errs;
    logic [31:0] words [4];
    logic [31:0] rd;
    logic        err;
    errs = err_count;
    apb_write(REG_CONFIG, 32'd2, err);
    for (int i = 0; i < 4; i++) begin
      words[2'(i)] = $random(seed);
      load_word(2'd2, words[2'(i)]);
    end
    for (int i = 0; i < 4; i++) begin
      apb_read(REG_RXDATA, rd, err);
      rx_expected++;
      compare_value("read word", rd, words[2'(i)]);
      compare_value("read error flag", 32'(err), 32'd0);
    end
    apb_read(REG_RXCOUNT, rd, err);
    compare_value("rxcount after reads", rd, 32'(rx_expected));
    report_test("word_reads", errs);
  endtask

  task automatic back_pressure();
    int          errs;
    int          strobes;
    logic [31:0] word;
    logic [5:0]  base;
    logic        err;
    errs = err_count;
    apb_write(REG_CONFIG, 32'd1, err);
    set_ready(4'b1101);
    word    = $random(seed);
    base    = model.tx_ptr[1];
    strobes = model.strobe_cnt;
    fork
      apb_write(REG_TXDATA, word, err);
      begin
        // Ready comes back well inside the timeout
        repeat (TIMEOUT_CYCLES / 2) @(negedge clk);
        compare_value("strobes while stalled", model.strobe_cnt - strobes, 32'd0);
        rdy_ctrl = 4'hF;
      end
    join
    tx_expected++;
    compare_value("stalled write error flag", 32'(err), 32'd0);
    compare_value("stalled write count", 32'(model.tx_ptr[1] - base), 32'd1);
    compare_value("stalled write word", model.tx_mem[1][base], word);
    report_test("back_pressure", errs);
  endtask

  task automatic timeout_and_errors();
    int          errs;
    int          strobes;
    logic [31:0] rd;
    logic [5:0]  base;
    logic        err;
    errs = err_count;
    apb_write(REG_CONFIG, 32'd3, err);
    set_ready(4'b0111);
    strobes = model.strobe_cnt;
    base    = model.tx_ptr[3];
    apb_write(REG_TXDATA, $random(seed), err);
    compare_value("timeout error flag", 32'(err), 32'd1);
    compare_value("timeout not too early", 32'(last_waits >= TIMEOUT_CYCLES), 32'd1);
    compare_value("strobes on timeout", model.strobe_cnt - strobes, 32'd0);
    compare_value("words on timeout", 32'(model.tx_ptr[3] - base), 32'd0);
    set_ready(4'hF);
    apb_read(8'h20, rd, err);
    compare_value("unmapped address error flag", 32'(err), 32'd1);
    apb_write(REG_RXDATA, 32'h0, err);
    compare_value("rxdata write error flag", 32'(err), 32'd1);
    apb_read(REG_TXDATA, rd, err);
    compare_value("txdata read error flag", 32'(err), 32'd1);
    // A timed out write is not a transfer
    apb_read(REG_TXCOUNT, rd, err);
    compare_value("txcount after timeout", rd, 32'(tx_expected));
    report_test("timeout_and_errors", errs);
  endtask

  task automatic pktend_and_clear();
    int          errs;
    int          pkts;
    int          total;
    logic [31:0] rd;
    logic        err;
    errs = err_count;
    apb_write(REG_CONFIG, 32'd2, err);
    pkts  = model.pktend_cnt[2];
    total = model.pktend_total;
    apb_write(REG_PKTEND, 32'h0, err);
    compare_value("pktend error flag", 32'(err), 32'd0);
    compare_value("pktend on socket 2", model.pktend_cnt[2] - pkts, 32'd1);
    compare_value("pktend on all sockets", model.pktend_total - total, 32'd1);
    apb_write(REG_TXCOUNT, 32'hFFFF, err);
    apb_read(REG_TXCOUNT, rd, err);
    compare_value("txcount after clear", rd, 32'd0);
    apb_write(REG_RXCOUNT, 32'h1, err);
    apb_read(REG_RXCOUNT, rd, err);
    compare_value("rxcount after clear", rd, 32'd0);
    compare_value("model protocol errors", model.proto_err_cnt, 32'd0);
    report_test("pktend_and_clear", errs);
  endtask

  // ********************************************************
  // Main sequence and watchdog
  // ********************************************************

  initial begin
    seed        = 32'h42a3;
    err_count   = 0;
    check_count = 0;
    last_waits  = 0;
    tx_expected = 0;
    rx_expected = 0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    rdy_ctrl    = 4'b1010;
    load        = 1'b0;
    load_socket = '0;
    load_data   = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_and_registers();
    word_writes();
    word_reads();
    back_pressure();
    timeout_and_errors();
    pktend_and_clear();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: test/fx3_device_model.sv
// ********************************************************
// Behavioral model of the USB 3.0 bridge chip in slave
// FIFO mode, as seen from the FPGA pins
// Each socket has a receive store filled by slwr_n cycles
// and a transmit FIFO that the testbench loads for reads
// Read data appears READ_LATENCY cycles after slrd_n
// ********************************************************

module fx3_device_model #(
  parameter int READ_LATENCY = 2
) (
  input  logic        pclk_i,
  input  logic        rst_n_i,
  input  logic [3:0]  ready_i,
  input  logic        load_i,
  input  logic [1:0]  load_socket_i,
  input  logic [31:0] load_data_i,
  input  logic [1:0]  addr_i,
  input  logic [31:0] data_i,
  input  logic        data_t_i,
  input  logic        slcs_n_i,
  input  logic        slrd_n_i,
  input  logic        sloe_n_i,
  input  logic        slwr_n_i,
  input  logic        pktend_n_i,
  output logic [3:0]  fifo_rdy_o,
  output logic [31:0] data_o
);

  localparam int DEPTH = 64;

  // One store per socket for words written by the FPGA
  logic [31:0] tx_mem [4][DEPTH];
  logic [5:0]  tx_ptr [4];
  // Words waiting to be read by the FPGA
  logic [31:0] rx_mem [4][DEPTH];
  logic [5:0]  rx_wr [4];
  logic [5:0]  rx_rd [4];
  // Event counters that the testbench inspects
  int          pktend_cnt [4];
  int          pktend_total;
  int          strobe_cnt;
  int          proto_err_cnt;

  // Read pipeline with the newest word in the low 32 bits
  logic [(READ_LATENCY+1)*32-1:0] pipe;
  logic [31:0] rd_word;
  logic        rd_cycle;

  // Readiness is set directly by the testbench
  assign fifo_rdy_o = ready_i;

  assign rd_cycle = ~slcs_n_i & ~slrd_n_i;
  assign rd_word  = rd_cycle ? rx_mem[addr_i][rx_rd[addr_i]] : 32'h0;
  // The word is on the bus only in its one valid cycle
  // and only while the output enable is held low
  assign data_o   = sloe_n_i ? 32'h0 : pipe[READ_LATENCY*32-1 -: 32];

  // ********************************************************
  // Bus cycle handling
  // ********************************************************

  always @(posedge pclk_i or negedge rst_n_i) begin
    int bad;
    bad = 0;
    if (!rst_n_i) begin
      for (int s = 0; s < 4; s++) begin
        tx_ptr[2'(s)]     <= '0;
        rx_wr[2'(s)]      <= '0;
        rx_rd[2'(s)]      <= '0;
        pktend_cnt[2'(s)] <= 0;
      end
      pktend_total  <= 0;
      strobe_cnt    <= 0;
      proto_err_cnt <= 0;
      pipe          <= '0;
    end else begin
      if (load_i) begin
        rx_mem[load_socket_i][rx_wr[load_socket_i]] <= load_data_i;
        rx_wr[load_socket_i] <= rx_wr[load_socket_i] + 6'd1;
      end
      pipe <= {pipe[READ_LATENCY*32-1:0], rd_word};
      // Both sides driving the data bus at once is contention
      if (!sloe_n_i && !data_t_i) begin
        bad = bad + 1;
      end
      if (!slcs_n_i) begin
        strobe_cnt <= strobe_cnt + 1;
        if (!slwr_n_i) begin
          // The FPGA must drive the bus while writing
          if (data_t_i) begin
            bad = bad + 1;
          end
          tx_mem[addr_i][tx_ptr[addr_i]] <= data_i;
          tx_ptr[addr_i] <= tx_ptr[addr_i] + 6'd1;
        end
        if (!slrd_n_i) begin
          // A read needs the output enable and a word to give
          if (sloe_n_i || rx_rd[addr_i] == rx_wr[addr_i]) begin
            bad = bad + 1;
          end
          rx_rd[addr_i] <= rx_rd[addr_i] + 6'd1;
        end
        if (!pktend_n_i) begin
          pktend_cnt[addr_i] <= pktend_cnt[addr_i] + 1;
          pktend_total       <= pktend_total + 1;
        end
      end
      proto_err_cnt <= proto_err_cnt + bad;
    end
  end

endmodule
